// File: list.f
+incdir+source
source/ex_pkg.sv
source/int_alu.sv
source/pipe_mult.sv
source/complete_arbiter.sv
source/exec_stage.sv
sim/exec_stage_sva.sv
sim/exec_stage_tb.sv

// File: run.sh
#!/bin/sh
set -e
verilator --binary --assert -f list.f --top-module exec_stage_tb -o Vexec_stage_tb
status=0
./obj_dir/Vexec_stage_tb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: sim/exec_stage_sva.sv
// Bound assertions on the completion arbiter's credit, buffer and reset rules
`timescale 1ns/1ps
`include "ex_defs.svh"

module exec_stage_sva (
    input logic             clock,
    input logic             reset,
    input logic             out_valid,
    input logic             alu_credit,
    input logic             mult_credit,
    input ex_pkg::credit_t  out_credits,
    input ex_pkg::credit_t  alu_count,
    input ex_pkg::credit_t  mult_count
);
    import ex_pkg::*;

    // The counter still holds the credit of the result on out_valid
    out_valid_has_credit: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> out_credits != '0)
        else $error("out_valid raised with the downstream credit counter at zero");

    ////////////////////
    // Buffer occupancy
    alu_buffer_bound: assert property (@(posedge clock) disable iff (reset)
        alu_count <= credit_t'(`EX_BUF_DEPTH))
        else $error("ALU completion buffer holds more than its depth");

    mult_buffer_bound: assert property (@(posedge clock) disable iff (reset)
        mult_count <= credit_t'(`EX_BUF_DEPTH))
        else $error("multiplier completion buffer holds more than its depth");

    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !out_valid && !alu_credit && !mult_credit)
        else $error("arbiter outputs not idle in the cycle after reset");

endmodule

bind complete_arbiter exec_stage_sva sva_0 (
    .clock       (clock),
    .reset       (reset),
    .out_valid   (out_valid),
    .alu_credit  (alu_credit),
    .mult_credit (mult_credit),
    .out_credits (out_credits),
    .alu_count   (count[0]),
    .mult_count  (count[1])
);

// File: sim/exec_stage_tb.sv
// Execute stage testbench with data file stimulus, credit-limited issue and result checks by tag
`timescale 1ns/1ps
`include "ex_defs.svh"

module exec_stage_tb;
    import ex_pkg::*;

    localparam int MAX_OPS = 16;
    // Quiet cycles after reset before the first issue
    localparam int IDLE_CYCLES = 4;

    logic  clock;
    logic  reset;
    logic  alu_issue;
    logic  mult_issue;
    func_t func;
    xlen_t rs1_value;
    xlen_t rs2_value;
    xlen_t imm;
    xlen_t pc;
    logic  opb_is_imm;
    tag_t  tag;
    logic  out_credit;
    logic  out_valid;
    xlen_t out_result;
    tag_t  out_tag;
    logic  out_take;
    logic  alu_credit;
    logic  mult_credit;

    ////////////////////
    // Operation table with one row per data line
    logic  op_unit    [MAX_OPS];
    func_t op_func    [MAX_OPS];
    xlen_t op_rs1     [MAX_OPS];
    xlen_t op_rs2     [MAX_OPS];
    xlen_t op_imm     [MAX_OPS];
    xlen_t op_pc      [MAX_OPS];
    logic  op_imm_sel [MAX_OPS];
    xlen_t exp_result [MAX_OPS];
    logic  exp_take   [MAX_OPS];
    logic  retired    [MAX_OPS];

    // Issue order per unit with the next expected result at the front
    int alu_order  [$];
    int mult_order [$];

    int         num_ops;
    int         next_op;
    int         retired_count;
    int         cycle_count;
    int         cycle_limit;
    int         sent_count;
    int         returned_count;
    int         held_results;
    credit_t    alu_credits;
    credit_t    mult_credits;
    logic [7:0] lfsr;

    exec_stage dut (
        .clock       (clock),
        .reset       (reset),
        .alu_issue   (alu_issue),
        .mult_issue  (mult_issue),
        .func        (func),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .imm         (imm),
        .pc          (pc),
        .opb_is_imm  (opb_is_imm),
        .tag         (tag),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_result  (out_result),
        .out_tag     (out_tag),
        .out_take    (out_take),
        .alu_credit  (alu_credit),
        .mult_credit (mult_credit)
    );

    always #50 clock = ~clock;

    ////////////////////
    // Failure reporting and compares
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_result(input string name, input xlen_t actual, input xlen_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_tag(input string name, input tag_t actual, input tag_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_take(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_credit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    // Fibonacci LFSR with taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    ////////////////////
    // Data file
    task automatic load_testdata();
        int          fd;
        int          fields;
        int          unit;
        int          imm_sel;
        int          take;
        logic [31:0] f;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] i;
        logic [31:0] p;
        logic [31:0] r;
        string       line;
        fd = $fopen("sim/exec_stage_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the test data file");
        end
        while ($fgets(line, fd) != 0) begin
            // Skip comments and blank lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                 unit, f, a, b, i, p, imm_sel, r, take);
                if (fields != 9) begin
                    fail_run("a test data line does not hold nine fields");
                end
                if (num_ops == MAX_OPS) begin
                    fail_run("the test data file holds more lines than there are tags");
                end
                op_unit[num_ops]    = unit[0];
                op_func[num_ops]    = f[`EX_FUNC_W-1:0];
                op_rs1[num_ops]     = a;
                op_rs2[num_ops]     = b;
                op_imm[num_ops]     = i;
                op_pc[num_ops]      = p;
                op_imm_sel[num_ops] = imm_sel[0];
                exp_result[num_ops] = r;
                exp_take[num_ops]   = take[0];
                num_ops++;
            end
        end
        $fclose(fd);
        if (num_ops == 0) begin
            fail_run("the test data file holds no operations");
        end
    endtask

    ////////////////////
    // Issuer, consumer and scoreboard

    // Issue in file order and stall while the target unit has no credit
    task automatic issue_next();
        logic to_mult;
        alu_issue  <= 1'b0;
        mult_issue <= 1'b0;
        if (next_op < num_ops) begin
            to_mult = op_unit[next_op];
            if (to_mult ? mult_credits != '0 : alu_credits != '0) begin
                func       <= op_func[next_op];
                rs1_value  <= op_rs1[next_op];
                rs2_value  <= op_rs2[next_op];
                imm        <= op_imm[next_op];
                pc         <= op_pc[next_op];
                opb_is_imm <= op_imm_sel[next_op];
                tag        <= tag_t'(next_op % 16);
                if (to_mult) begin
                    mult_issue   <= 1'b1;
                    mult_credits = mult_credits - credit_t'(1);
                    mult_order.push_back(next_op);
                end else begin
                    alu_issue   <= 1'b1;
                    alu_credits = alu_credits - credit_t'(1);
                    alu_order.push_back(next_op);
                end
                next_op++;
            end
        end
    endtask

    // Hand back one credit only when the LFSR allows it
    task automatic return_credit();
        logic allow;
        out_credit <= 1'b0;
        if (held_results > 0) begin
            lfsr  = lfsr_step(lfsr);
            allow = lfsr[0];
            if (allow) begin
                out_credit <= 1'b1;
                held_results--;
                returned_count++;
            end
        end
    endtask

    task automatic take_result();
        int index;
        int expected_index;
        index = int'(out_tag);
        if (next_op == 0) begin
            fail_run("out_valid was raised before any operation was issued");
        end
        if (index >= num_ops || retired[index]) begin
            fail_run($sformatf("tag %0d came back without an outstanding operation", index));
        end
        sent_count++;
        held_results++;
        if (sent_count > returned_count + `EX_OUT_CREDITS) begin
            fail_run("a result was sent without a downstream credit");
        end
        if (op_unit[index]) begin
            if (mult_order.size() == 0) begin
                fail_run("a multiplier result came back with nothing issued to it");
            end
            expected_index = mult_order.pop_front();
        end else begin
            if (alu_order.size() == 0) begin
                fail_run("an ALU result came back with nothing issued to it");
            end
            expected_index = alu_order.pop_front();
        end
        check_tag("out_tag", out_tag, tag_t'(expected_index % 16));
        check_result("out_result", out_result, exp_result[index]);
        check_take("out_take", out_take, exp_take[index]);
        // The sending unit gets its issue credit back in the same cycle
        check_credit("alu_credit", alu_credit, !op_unit[index]);
        check_credit("mult_credit", mult_credit, op_unit[index]);
        retired[index] = 1'b1;
        retired_count++;
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        alu_issue      = 1'b0;
        mult_issue     = 1'b0;
        func           = '0;
        rs1_value      = '0;
        rs2_value      = '0;
        imm            = '0;
        pc             = '0;
        opb_is_imm     = 1'b0;
        tag            = '0;
        out_credit     = 1'b0;
        num_ops        = 0;
        next_op        = 0;
        retired_count  = 0;
        cycle_count    = 0;
        sent_count     = 0;
        returned_count = 0;
        held_results   = 0;
        alu_credits    = credit_t'(`EX_BUF_DEPTH);
        mult_credits   = credit_t'(`EX_BUF_DEPTH);
        lfsr           = 8'd37;
        for (int n = 0; n < MAX_OPS; n++) begin
            retired[n] = 1'b0;
        end
        load_testdata();
        cycle_limit = 40 * num_ops + 100;

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        while (retired_count < num_ops) begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                fail_run("timeout: not every result retired within the cycle limit");
            end
            alu_credits  = alu_credits + credit_t'(alu_credit);
            mult_credits = mult_credits + credit_t'(mult_credit);
            if (out_valid) begin
                take_result();
            end else begin
                check_credit("alu_credit", alu_credit, 1'b0);
                check_credit("mult_credit", mult_credit, 1'b0);
            end
            return_credit();
            if (cycle_count > IDLE_CYCLES) begin
                issue_next();
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: sim/exec_stage_testdata.txt
# unit func rs1 rs2 imm pc opb_is_imm expected_result expected_take, all hexadecimal
# unit 0 is the ALU and 1 the multiplier, the line index is the reorder tag
1 0 7fffffff 7fffffff 00000000 00000000 0 00000001 0
1 1 80000000 80000000 00000000 00000000 0 40000000 0
1 2 ffffffff ffffffff 00000000 00000000 0 fffffffe 0
0 0 00000010 deadbeef fffffff0 00000000 1 00000000 0
0 1 00000005 00000007 00000000 00000000 0 fffffffe 0
1 1 ffffffff 00000002 00000000 00000000 0 ffffffff 0
0 a 12345678 12345678 00000010 00001000 0 00001010 1
0 5 ffffffff 00000000 00000001 00000000 1 00000001 0
0 6 ffffffff 00000001 00000000 00000000 0 00000000 0
0 c 00000005 fffffffb fffffff8 00002000 0 00001ff8 0
1 0 12345678 00000010 00000000 00000000 0 23456780 0
0 9 80000000 00000000 00000004 00000000 1 f8000000 0
0 e 00000005 fffffffb 00000100 00003000 0 00003100 1
0 d ffffffff 00000000 00000004 00004000 0 00004004 0
0 4 f0f0f0f0 ff00ff00 00000000 00000000 0 0ff00ff0 0
0 b 00000001 00000001 fffff000 00005000 0 00004000 0

// File: source/complete_arbiter.sv
// Completion buffers, round-robin result select, downstream credits and issue-credit return
`timescale 1ns/1ps
`include "ex_defs.svh"

module complete_arbiter (
    input  logic           clock,
    input  logic           reset,
    input  logic           alu_done,
    input  ex_pkg::xlen_t  alu_result,
    input  ex_pkg::tag_t   alu_tag,
    input  logic           alu_take,
    input  logic           mult_done,
    input  ex_pkg::xlen_t  mult_result,
    input  ex_pkg::tag_t   mult_tag,
    input  logic           out_credit,
    output logic           out_valid,
    output ex_pkg::xlen_t  out_result,
    output ex_pkg::tag_t   out_tag,
    output logic           out_take,
    output logic           alu_credit,
    output logic           mult_credit
);
    import ex_pkg::*;

    localparam int PTR_W = $clog2(`EX_BUF_DEPTH);

    // Index 0 is the ALU, index 1 the multiplier, matching grant_t
    logic  in_done   [2];
    xlen_t in_result [2];
    tag_t  in_tag    [2];
    logic  in_take   [2];

    xlen_t buf_result [2][`EX_BUF_DEPTH];
    tag_t  buf_tag    [2][`EX_BUF_DEPTH];
    logic  buf_take   [2][`EX_BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr [2];
    logic [PTR_W-1:0] rd_ptr [2];
    credit_t          count  [2];

    logic    ready [2];
    logic    pop   [2];
    logic    send;
    logic    can_send;
    grant_t  pick;
    grant_t  last_grant;
    credit_t out_credits;

    assign in_done[0]   = alu_done;
    assign in_result[0] = alu_result;
    assign in_tag[0]    = alu_tag;
    assign in_take[0]   = alu_take;
    assign in_done[1]   = mult_done;
    assign in_result[1] = mult_result;
    assign in_tag[1]    = mult_tag;
    assign in_take[1]   = 1'b0;

    ////////////////////
    // Selection
    // A unit is ready with a stored entry or one arriving this cycle
    always_comb begin
        for (int u = 0; u < 2; u++) begin
            ready[u] = count[u] != '0 || in_done[u];
        end
        if (ready[0] && ready[1]) begin
            pick = (last_grant == GRANT_ALU) ? GRANT_MULT : GRANT_ALU;
        end else if (ready[1]) begin
            pick = GRANT_MULT;
        end else begin
            pick = GRANT_ALU;
        end
    end

    // A result on out_valid still holds its credit in the counter
    assign can_send = out_credits > credit_t'(out_valid);
    assign send     = can_send && (ready[0] || ready[1]);
    assign pop[0]   = send && pick == GRANT_ALU;
    assign pop[1]   = send && pick == GRANT_MULT;

    ////////////////////
    // Buffers
    always_ff @(posedge clock) begin
        for (int u = 0; u < 2; u++) begin
            if (in_done[u]) begin
                buf_result[u][wr_ptr[u]] <= in_result[u];
                buf_tag[u][wr_ptr[u]]    <= in_tag[u];
                buf_take[u][wr_ptr[u]]   <= in_take[u];
            end
        end
    end

    // An empty buffer passes its arriving entry straight on, so both pointers move
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int u = 0; u < 2; u++) begin
                wr_ptr[u] <= '0;
                rd_ptr[u] <= '0;
                count[u]  <= '0;
            end
        end else begin
            for (int u = 0; u < 2; u++) begin
                wr_ptr[u] <= wr_ptr[u] + PTR_W'(in_done[u]);
                rd_ptr[u] <= rd_ptr[u] + PTR_W'(pop[u]);
                count[u]  <= count[u] + credit_t'(in_done[u]) - credit_t'(pop[u]);
            end
        end
    end

    ////////////////////
    // Output and credits
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid   <= 1'b0;
            alu_credit  <= 1'b0;
            mult_credit <= 1'b0;
            last_grant  <= GRANT_MULT;
            out_credits <= credit_t'(`EX_OUT_CREDITS);
        end else begin
            out_valid   <= send;
            alu_credit  <= pop[0];
            mult_credit <= pop[1];
            if (send) begin
                last_grant <= pick;
            end
            out_credits <= out_credits - credit_t'(out_valid) + credit_t'(out_credit);
        end
    end

    always_ff @(posedge clock) begin
        if (send) begin
            if (count[pick] == '0) begin
                out_result <= in_result[pick];
                out_tag    <= in_tag[pick];
                out_take   <= in_take[pick];
            end else begin
                out_result <= buf_result[pick][rd_ptr[pick]];
                out_tag    <= buf_tag[pick][rd_ptr[pick]];
                out_take   <= buf_take[pick][rd_ptr[pick]];
            end
        end
    end

endmodule

// File: source/ex_defs.svh
// Execute stage widths, buffer depths, credit counts, multiplier latency, function codes
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define EX_XLEN         32
`define EX_TAG_W        4
`define EX_FUNC_W       4
// Completion buffer entries per unit, also the issuer's starting credits
`define EX_BUF_DEPTH    4
`define EX_OUT_CREDITS  2
`define EX_MULT_STAGES  3

////////////////////
// ALU codes
`define FN_ADD   4'd0
`define FN_SUB   4'd1
`define FN_AND   4'd2
`define FN_OR    4'd3
`define FN_XOR   4'd4
`define FN_SLT   4'd5
`define FN_SLTU  4'd6
`define FN_SLL   4'd7
`define FN_SRL   4'd8
`define FN_SRA   4'd9

////////////////////
// Branch codes, shared space with the ALU codes
`define FN_BEQ   4'd10
`define FN_BNE   4'd11
`define FN_BLT   4'd12
`define FN_BGE   4'd13
`define FN_BLTU  4'd14
`define FN_BGEU  4'd15

////////////////////
// Multiplier codes, only seen by the multiplier
`define FN_MUL   4'd0
`define FN_MULH  4'd1
`define FN_MULHU 4'd2

`endif

// File: source/ex_pkg.sv
// Execute stage package with data, tag, function and credit types plus the grant enum

`include "ex_defs.svh"

package ex_pkg;

    ////////////////////
    // Data path vectors

    // One register value
    typedef logic [`EX_XLEN-1:0] xlen_t;

    // Reorder buffer slot
    typedef logic [`EX_TAG_W-1:0] tag_t;

    typedef logic [`EX_FUNC_W-1:0] func_t;

    ////////////////////
    // Flow control

    // Wide enough for the largest starting count, a full completion buffer
    typedef logic [$clog2(`EX_BUF_DEPTH + 1)-1:0] credit_t;

    // Unit that won the last arbitration, also used as buffer index
    typedef enum logic {
        GRANT_ALU  = 1'b0,
        GRANT_MULT = 1'b1
    } grant_t;

endpackage

// File: source/exec_stage.sv
// Execute stage top level with ALU, multiplier and completion arbiter
`timescale 1ns/1ps
`include "ex_defs.svh"

module exec_stage (
    input  logic           clock,
    input  logic           reset,
    input  logic           alu_issue,
    input  logic           mult_issue,
    input  ex_pkg::func_t  func,
    input  ex_pkg::xlen_t  rs1_value,
    input  ex_pkg::xlen_t  rs2_value,
    input  ex_pkg::xlen_t  imm,
    input  ex_pkg::xlen_t  pc,
    input  logic           opb_is_imm,
    input  ex_pkg::tag_t   tag,
    input  logic           out_credit,
    output logic           out_valid,
    output ex_pkg::xlen_t  out_result,
    output ex_pkg::tag_t   out_tag,
    output logic           out_take,
    output logic           alu_credit,
    output logic           mult_credit
);
    import ex_pkg::*;

    logic  alu_done;
    xlen_t alu_result;
    tag_t  alu_tag;
    logic  alu_take;
    logic  mult_done;
    xlen_t mult_result;
    tag_t  mult_tag;

    ////////////////////
    // Units
    int_alu alu_0 (
        .clock       (clock),
        .reset       (reset),
        .issue       (alu_issue),
        .func        (func),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .imm         (imm),
        .pc          (pc),
        .opb_is_imm  (opb_is_imm),
        .tag         (tag),
        .done        (alu_done),
        .result      (alu_result),
        .result_tag  (alu_tag),
        .take_branch (alu_take)
    );

    // Operand B is always rs2 here
    pipe_mult mult_0 (
        .clock      (clock),
        .reset      (reset),
        .issue      (mult_issue),
        .func       (func),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .tag        (tag),
        .done       (mult_done),
        .result     (mult_result),
        .result_tag (mult_tag)
    );

    ////////////////////
    // Completion
    complete_arbiter arbiter_0 (
        .clock       (clock),
        .reset       (reset),
        .alu_done    (alu_done),
        .alu_result  (alu_result),
        .alu_tag     (alu_tag),
        .alu_take    (alu_take),
        .mult_done   (mult_done),
        .mult_result (mult_result),
        .mult_tag    (mult_tag),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_result  (out_result),
        .out_tag     (out_tag),
        .out_take    (out_take),
        .alu_credit  (alu_credit),
        .mult_credit (mult_credit)
    );

endmodule

// File: source/int_alu.sv
// Integer ALU with operand select, branch compare and target, and registered result
`timescale 1ns/1ps
`include "ex_defs.svh"

module int_alu (
    input  logic           clock,
    input  logic           reset,
    input  logic           issue,
    input  ex_pkg::func_t  func,
    input  ex_pkg::xlen_t  rs1_value,
    input  ex_pkg::xlen_t  rs2_value,
    input  ex_pkg::xlen_t  imm,
    input  ex_pkg::xlen_t  pc,
    input  logic           opb_is_imm,
    input  ex_pkg::tag_t   tag,
    output logic           done,
    output ex_pkg::xlen_t  result,
    output ex_pkg::tag_t   result_tag,
    output logic           take_branch
);
    import ex_pkg::*;

    xlen_t opb;
    xlen_t alu_value;
    logic  is_branch;
    logic  branch_cond;

    // Immediate arrives already sign-extended
    assign opb = opb_is_imm ? imm : rs2_value;

    ////////////////////
    // Arithmetic and logic
    always_comb begin
        case (func)
            `FN_ADD:  alu_value = rs1_value + opb;
            `FN_SUB:  alu_value = rs1_value - opb;
            `FN_AND:  alu_value = rs1_value & opb;
            `FN_OR:   alu_value = rs1_value | opb;
            `FN_XOR:  alu_value = rs1_value ^ opb;
            `FN_SLT:  alu_value = xlen_t'($signed(rs1_value) < $signed(opb));
            `FN_SLTU: alu_value = xlen_t'(rs1_value < opb);
            `FN_SLL:  alu_value = rs1_value << opb[4:0];
            `FN_SRL:  alu_value = rs1_value >> opb[4:0];
            `FN_SRA:  alu_value = $signed(rs1_value) >>> opb[4:0];
            default:  alu_value = '0;
        endcase
    end

    ////////////////////
    // Branch condition, always on the two registers
    always_comb begin
        is_branch = 1'b1;
        case (func)
            `FN_BEQ:  branch_cond = rs1_value == rs2_value;
            `FN_BNE:  branch_cond = rs1_value != rs2_value;
            `FN_BLT:  branch_cond = $signed(rs1_value) < $signed(rs2_value);
            `FN_BGE:  branch_cond = $signed(rs1_value) >= $signed(rs2_value);
            `FN_BLTU: branch_cond = rs1_value < rs2_value;
            `FN_BGEU: branch_cond = rs1_value >= rs2_value;
            default: begin
                is_branch   = 1'b0;
                branch_cond = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= issue;
        end
    end

    // Branches report their target in place of an ALU value
    always_ff @(posedge clock) begin
        if (issue) begin
            result      <= is_branch ? pc + imm : alu_value;
            result_tag  <= tag;
            take_branch <= is_branch && branch_cond;
        end
    end

endmodule

// File: source/pipe_mult.sv
// Three-stage pipelined multiplier with low or high word select and tag pipeline
`timescale 1ns/1ps
`include "ex_defs.svh"

module pipe_mult (
    input  logic           clock,
    input  logic           reset,
    input  logic           issue,
    input  ex_pkg::func_t  func,
    input  ex_pkg::xlen_t  rs1_value,
    input  ex_pkg::xlen_t  rs2_value,
    input  ex_pkg::tag_t   tag,
    output logic           done,
    output ex_pkg::xlen_t  result,
    output ex_pkg::tag_t   result_tag
);
    import ex_pkg::*;

    localparam int STAGES = `EX_MULT_STAGES;

    logic [STAGES-1:0] valid_pipe;
    tag_t              tag_pipe [STAGES];
    // Function code is needed up to the word select in the last stage
    func_t             func_pipe [STAGES-1];

    logic                           op_signed;
    logic signed [`EX_XLEN:0]       ext_a;
    logic signed [`EX_XLEN:0]       ext_b;
    logic signed [`EX_XLEN:0]       op_a;
    logic signed [`EX_XLEN:0]       op_b;
    logic signed [2*`EX_XLEN+1:0]   full_product;
    logic [2*`EX_XLEN-1:0]          product;

    // One extra bit per operand covers MULH and MULHU with one signed multiplier
    assign op_signed = func != `FN_MULHU;
    assign ext_a = {op_signed & rs1_value[`EX_XLEN-1], rs1_value};
    assign ext_b = {op_signed & rs2_value[`EX_XLEN-1], rs2_value};
    assign full_product = op_a * op_b;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[STAGES-2:0], issue};
        end
    end

    ////////////////////
    // Tag and function code ride along
    always_ff @(posedge clock) begin
        tag_pipe[0]  <= tag;
        func_pipe[0] <= func;
        for (int i = 1; i < STAGES; i++) begin
            tag_pipe[i] <= tag_pipe[i-1];
        end
        for (int i = 1; i < STAGES - 1; i++) begin
            func_pipe[i] <= func_pipe[i-1];
        end
    end

    ////////////////////
    // Data stages
    always_ff @(posedge clock) begin
        op_a    <= ext_a;
        op_b    <= ext_b;
        product <= full_product[2*`EX_XLEN-1:0];
        if (func_pipe[STAGES-2] == `FN_MUL) begin
            result <= product[`EX_XLEN-1:0];
        end else begin
            result <= product[2*`EX_XLEN-1:`EX_XLEN];
        end
    end

    assign done       = valid_pipe[STAGES-1];
    assign result_tag = tag_pipe[STAGES-1];

endmodule
